/* jelly_peri.f */
src/jelly_peri_pkg.sv
src/jelly_wb_if.sv
src/jelly_peri_decoder.sv
src/jelly_timer.sv
src/jelly_irc.sv
src/jelly_uart_tx.sv
src/jelly_peri_top.sv
sim/jelly_peri_checker.sv
sim/tb_jelly_peri.sv

/* Makefile */
# Verilator build and run for the jelly peripheral subsystem

VERILATOR ?= verilator
TOP       ?= tb_jelly_peri
FILELIST  ?= jelly_peri.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator exit code alone is not enough
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_jelly_peri.sv */
// --------------------------------------------------------------------
// jelly peripheral testbench
// register table, timer periods, UART frames and interrupt handshake
// --------------------------------------------------------------------

`default_nettype none

module tb_jelly_peri;

	localparam int BAUD_DIV = 8;

	logic        clk;
	logic        reset;
	logic [11:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_we;
	logic [3:0]  wb_sel;
	logic        wb_stb;
	logic        wb_ack;
	logic        ext_irq;
	logic        irq;
	logic        irq_ack;
	logic        uart_tx;

	int          err_cnt = 0;
	int          access_cnt = 0;
	int          ack_cnt = 0;
	int          cycle = 0;
	bit          tbl_ready = 1'b0;
	logic [31:0] rng = 32'h9f89;
	logic [7:0]  rx_q[$];

	// register table columns
	string       t_name[$];
	bit          t_we[$];
	logic [11:0] t_adr[$];
	logic [31:0] t_wdat[$];
	logic [3:0]  t_sel[$];
	logic [31:0] t_exp[$];
	bit          t_cmp[$];

	jelly_peri_top #(
		.BAUD_DIV (BAUD_DIV)
	) UUT (
		.clk_i     (clk),
		.reset_i   (reset),
		.wb_adr_i  (wb_adr),
		.wb_dat_i  (wb_dat_w),
		.wb_dat_o  (wb_dat_r),
		.wb_we_i   (wb_we),
		.wb_sel_i  (wb_sel),
		.wb_stb_i  (wb_stb),
		.wb_ack_o  (wb_ack),
		.ext_irq_i (ext_irq),
		.irq_o     (irq),
		.irq_ack_i (irq_ack),
		.uart_tx_o (uart_tx)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (wb_ack)
			ack_cnt <= ack_cnt + 1;
	end

	// --------------------------------------------------------------------
	//  helpers
	// --------------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("ERR %s: expected %h, got %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic add_entry(input string name, input bit we, input logic [11:0] adr,
		input logic [31:0] wdat, input logic [3:0] sel, input logic [31:0] exp,
		input bit cmp);
		t_name.push_back(name);
		t_we.push_back(we);
		t_adr.push_back(adr);
		t_wdat.push_back(wdat);
		t_sel.push_back(sel);
		t_exp.push_back(exp);
		t_cmp.push_back(cmp);
	endtask

	// one strobe, held until ack or four cycles
	task automatic bus_access(input string name, input bit we, input logic [11:0] adr,
		input logic [31:0] wdat, input logic [3:0] sel, output logic [31:0] rdat);
		@(posedge clk);
		#1;
		wb_adr   = adr;
		wb_dat_w = wdat;
		wb_we    = we;
		wb_sel   = sel;
		wb_stb   = 1'b1;
		access_cnt++;
		repeat (4)
		begin
			@(posedge clk);
			#1;
			if (wb_ack)
				break;
		end
		rdat = wb_dat_r;
		assert (wb_ack)
		else
		begin
			$display("%s: bus access was not acknowledged within 4 cycles", name);
			err_cnt++;
		end
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic write_reg(input string name, input logic [11:0] adr,
		input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] unused;
		bus_access(name, 1'b1, adr, dat, sel, unused);
	endtask

	task automatic read_check(input string name, input logic [11:0] adr,
		input logic [31:0] exp);
		logic [31:0] rdat;
		bus_access(name, 1'b0, adr, 32'h0, 4'hf, rdat);
		check_equal(name, exp, rdat);
	endtask

	task automatic wait_irq(input string name, output int at);
		int n;
		n = 0;
		while (!irq && n < 64)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		at = cycle;
		assert (irq)
		else
		begin
			$display("%s: irq_o did not rise within 64 cycles", name);
			err_cnt++;
		end
	endtask

	task automatic ack_irq();
		irq_ack = 1'b1;
		@(posedge clk);
		#1;
		irq_ack = 1'b0;
	endtask

	task automatic pulse_ext();
		ext_irq = 1'b1;
		@(posedge clk);
		#1;
		ext_irq = 1'b0;
	endtask

	task automatic wait_frames(input string name, input int n);
		int cnt;
		cnt = 0;
		while (rx_q.size() < n && cnt < 12 * 10 * BAUD_DIV)
		begin
			@(posedge clk);
			#1;
			cnt++;
		end
		assert (rx_q.size() >= n)
		else
		begin
			$display("%s: expected UART frame never arrived", name);
			err_cnt++;
		end
	endtask

	// --------------------------------------------------------------------
	//  UART sampler, bit centers counted from the start edge
	// --------------------------------------------------------------------

	initial
	begin : frame_sampler
		logic [9:0] bits;
		forever
		begin
			@(negedge clk);
			if (!reset && uart_tx === 1'b0)
			begin
				repeat (BAUD_DIV / 2) @(negedge clk);
				for (int i = 0; i < 10; i++)
				begin
					bits[i] = uart_tx;
					if (i < 9)
						repeat (BAUD_DIV) @(negedge clk);
				end
				assert (bits[0] === 1'b0 && bits[9] === 1'b1)
				else
				begin
					$display("uart frame has a bad start or stop bit");
					err_cnt++;
				end
				rx_q.push_back(bits[8:1]);
			end
		end
	end

	// --------------------------------------------------------------------
	//  main sequence
	// --------------------------------------------------------------------

	initial
	begin
		logic [31:0] rdat;
		logic [31:0] cmp;
		logic [7:0]  b0;
		logic [7:0]  b1;
		logic [7:0]  b2;
		int          t_irq[5];
		int          tmp;

		reset    = 1'b1;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_we    = 1'b0;
		wb_sel   = '0;
		wb_stb   = 1'b0;
		ext_irq  = 1'b0;
		irq_ack  = 1'b0;

		rng = lcg_next(rng);
		cmp = 32'd2 + {29'd0, rng[18:16]};
		rng = lcg_next(rng);
		b0  = rng[23:16];
		rng = lcg_next(rng);
		b1  = rng[23:16];
		if (b1 == b0)
			b1 = ~b0;
		rng = lcg_next(rng);
		b2  = rng[23:16];

		add_entry("irc_en_wr",    1'b1, 12'h000, 32'h5,         4'h1, 32'h0,         1'b0);
		add_entry("irc_en_rd",    1'b0, 12'h000, 32'h0,         4'hf, 32'h5,         1'b1);
		add_entry("irc_en_lane",  1'b1, 12'h000, 32'hffff_ff02, 4'he, 32'h0,         1'b0);
		add_entry("irc_en_lrd",   1'b0, 12'h000, 32'h0,         4'hf, 32'h5,         1'b1);
		add_entry("irc_en_wr2",   1'b1, 12'h000, 32'h2,         4'h1, 32'h0,         1'b0);
		add_entry("irc_en_rd2",   1'b0, 12'h000, 32'h0,         4'hf, 32'h2,         1'b1);
		add_entry("irc_en_off",   1'b1, 12'h000, 32'h0,         4'h1, 32'h0,         1'b0);
		add_entry("tmr_cmp_wr",   1'b1, 12'h104, 32'h1122_3344, 4'hf, 32'h0,         1'b0);
		add_entry("tmr_cmp_rd",   1'b0, 12'h104, 32'h0,         4'hf, 32'h1122_3344, 1'b1);
		add_entry("tmr_cmp_lane", 1'b1, 12'h104, 32'haabb_ccdd, 4'h5, 32'h0,         1'b0);
		add_entry("tmr_cmp_lrd",  1'b0, 12'h104, 32'h0,         4'hf, 32'h11bb_33dd, 1'b1);
		add_entry("tmr_ctl_wr",   1'b1, 12'h100, 32'h3,         4'h1, 32'h0,         1'b0);
		add_entry("tmr_ctl_rd",   1'b0, 12'h100, 32'h0,         4'hf, 32'h1,         1'b1);
		add_entry("tmr_ctl_off",  1'b1, 12'h100, 32'h0,         4'h1, 32'h0,         1'b0);
		add_entry("tmr_ctl_rd0",  1'b0, 12'h100, 32'h0,         4'hf, 32'h0,         1'b1);
		add_entry("unmap_rd",     1'b0, 12'h300, 32'h0,         4'hf, 32'h0,         1'b1);
		add_entry("unmap_wr",     1'b1, 12'hf04, 32'hffff_ffff, 4'hf, 32'h0,         1'b0);
		add_entry("unmap_rd2",    1'b0, 12'hf04, 32'h0,         4'hf, 32'h0,         1'b1);
		add_entry("uart_idle",    1'b0, 12'h204, 32'h0,         4'hf, 32'h0,         1'b1);
		add_entry("irc_pend_rd",  1'b0, 12'h004, 32'h0,         4'hf, 32'h0,         1'b1);
		tbl_ready = 1'b1;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < t_name.size(); i++)
		begin
			bus_access(t_name[i], t_we[i], t_adr[i], t_wdat[i], t_sel[i], rdat);
			if (t_cmp[i])
				check_equal(t_name[i], t_exp[i], rdat);
		end

		// timer, match requests come compare+1 cycles apart
		write_reg("tmr_cmp", 12'h104, cmp, 4'hf);
		write_reg("irc_en_tmr", 12'h000, 32'h1, 4'h1);
		write_reg("tmr_start", 12'h100, 32'h3, 4'h1);
		bus_access("tmr_cnt", 1'b0, 12'h108, 32'h0, 4'hf, rdat);
		assert (rdat <= cmp)
		else
		begin
			$display("ERR tmr_cnt: expected <= %h, got %h", cmp, rdat);
			err_cnt++;
		end
		for (int k = 0; k < 5; k++)
		begin
			wait_irq("tmr_irq", t_irq[k]);
			ack_irq();
		end
		for (int k = 1; k < 5; k++)
			check_equal("tmr_period", cmp + 32'd1, 32'(t_irq[k] - t_irq[k-1]));
		write_reg("irc_en_none", 12'h000, 32'h0, 4'h1);
		write_reg("tmr_stop", 12'h100, 32'h0, 4'h1);
		if (irq)
			ack_irq();
		write_reg("irc_pend_clr", 12'h004, 32'h7, 4'h1);

		// UART, second byte lands while busy
		write_reg("uart_tx0", 12'h200, {24'h0, b0}, 4'h1);
		read_check("uart_busy", 12'h204, 32'h1);
		write_reg("uart_drop", 12'h200, {24'h0, b1}, 4'h1);
		wait_frames("uart_frame0", 1);
		repeat (12 * BAUD_DIV) @(posedge clk);
		#1;
		check_equal("uart_frame_cnt", 32'd1, 32'(rx_q.size()));
		if (rx_q.size() > 0)
			check_equal("uart_byte0", {24'h0, b0}, {24'h0, rx_q[0]});
		read_check("uart_done", 12'h204, 32'h0);
		write_reg("uart_tx1", 12'h200, {24'h0, b2}, 4'h1);
		wait_frames("uart_frame1", 2);
		if (rx_q.size() > 1)
			check_equal("uart_byte1", {24'h0, b2}, {24'h0, rx_q[1]});

		// priority, UART pending is already set
		pulse_ext();
		write_reg("tmr_cmp0", 12'h104, 32'h0, 4'hf);
		write_reg("tmr_run", 12'h100, 32'h3, 4'h1);
		write_reg("tmr_halt", 12'h100, 32'h0, 4'h1);
		read_check("irc_pend_all", 12'h004, 32'h7);
		write_reg("irc_en_all", 12'h000, 32'h7, 4'h1);
		for (int k = 0; k < 3; k++)
		begin
			wait_irq("irc_prio", tmp);
			read_check("irc_factor", 12'h008, 32'(k));
			ack_irq();
			read_check("irc_pend_drop", 12'h004, (32'h7 << (k + 1)) & 32'h7);
		end
		repeat (4) @(posedge clk);
		#1;
		check_equal("irq_quiet", 32'h0, {31'h0, irq});

		// masking of the external factor
		write_reg("irc_en_mask", 12'h000, 32'h3, 4'h1);
		pulse_ext();
		read_check("irc_pend_ext", 12'h004, 32'h4);
		repeat (4) @(posedge clk);
		#1;
		check_equal("irq_masked", 32'h0, {31'h0, irq});
		write_reg("irc_en_ext", 12'h000, 32'h7, 4'h1);
		wait_irq("irq_unmasked", tmp);
		read_check("irc_factor_ext", 12'h008, 32'h2);
		write_reg("irc_pend_w1c", 12'h004, 32'h4, 4'h1);
		read_check("irc_pend_gone", 12'h004, 32'h0);
		ack_irq();

		repeat (2) @(posedge clk);
		#1;
		check_equal("ack_count", 32'(access_cnt), 32'(ack_cnt));
		$display("errors: %0d", err_cnt);
		if (err_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog sized from the table and the longest UART wait
	initial
	begin : watchdog
		int limit;
		wait (tbl_ready);
		limit = t_name.size() * 20 + 12 * 10 * BAUD_DIV;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit);
		err_cnt++;
		$display("errors: %0d", err_cnt);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/jelly_peri_checker.sv */
// --------------------------------------------------------------------
// jelly peripheral protocol checker
// bus handshake, interrupt release and UART line during reset
// --------------------------------------------------------------------

`default_nettype none

module jelly_peri_checker
	(
		input  wire logic clk_i,
		input  wire logic reset_i,
		input  wire logic stb_i,
		input  wire logic ack_i,
		input  wire logic irq_i,
		input  wire logic irq_ack_i,
		input  wire logic tx_i
	);

	// ack answers a strobe from the previous edge
	ack_after_stb: assert property (@(posedge clk_i) disable iff (reset_i)
		ack_i |-> $past(stb_i))
		else $error("bus ack without a preceding strobe");

	ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
		ack_i |=> !ack_i)
		else $error("bus ack held for two cycles");

	// request is held until the CPU acknowledges
	irq_release: assert property (@(posedge clk_i) disable iff (reset_i)
		$fell(irq_i) |-> $past(irq_ack_i))
		else $error("irq dropped without an acknowledge");

	tx_idle_reset: assert property (@(posedge clk_i)
		reset_i && $past(reset_i) |-> tx_i)
		else $error("UART line low during reset");

endmodule

bind jelly_peri_top jelly_peri_checker i_checker
(
	.clk_i     (clk_i),
	.reset_i   (reset_i),
	.stb_i     (wb_stb_i),
	.ack_i     (wb_ack_o),
	.irq_i     (irq_o),
	.irq_ack_i (irq_ack_i),
	.tx_i      (uart_tx_o)
);

`default_nettype wire

/* src/jelly_peri_top.sv */
// --------------------------------------------------------------------
// jelly peripheral subsystem
// decoder, interrupt controller, timer and UART transmitter
// --------------------------------------------------------------------

`default_nettype none

module jelly_peri_top
	import jelly_peri_pkg::*;
	#(
		parameter int BAUD_DIV    = 8,
		parameter int TIMER_WIDTH = 32
	)
	(
		input  wire logic                    clk_i,
		input  wire logic                    reset_i,

		// peripheral bus
		input  wire logic [WB_ADR_WIDTH-1:0] wb_adr_i,
		input  wire logic [WB_DAT_WIDTH-1:0] wb_dat_i,
		output logic      [WB_DAT_WIDTH-1:0] wb_dat_o,
		input  wire logic                    wb_we_i,
		input  wire logic [WB_SEL_WIDTH-1:0] wb_sel_i,
		input  wire logic                    wb_stb_i,
		output logic                         wb_ack_o,

		// interrupts
		input  wire logic                    ext_irq_i,
		output logic                         irq_o,
		input  wire logic                    irq_ack_i,

		output logic                         uart_tx_o
	);

	jelly_wb_if irc_bus ();
	jelly_wb_if timer_bus ();
	jelly_wb_if uart_bus ();

	logic                  timer_match;
	logic                  uart_done;
	logic [FACTOR_NUM-1:0] factor;

	// interrupt map
	assign factor[FACTOR_TIMER]   = timer_match;
	assign factor[FACTOR_UART_TX] = uart_done;
	assign factor[FACTOR_EXT]     = ext_irq_i;

	jelly_peri_decoder i_decoder
	(
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_we_i   (wb_we_i),
		.wb_sel_i  (wb_sel_i),
		.wb_stb_i  (wb_stb_i),
		.wb_ack_o  (wb_ack_o),
		.irc_bus   (irc_bus),
		.timer_bus (timer_bus),
		.uart_bus  (uart_bus)
	);

	jelly_irc i_irc
	(
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.bus       (irc_bus),
		.factor_i  (factor),
		.irq_o     (irq_o),
		.irq_ack_i (irq_ack_i)
	);

	jelly_timer #(
		.TIMER_WIDTH (TIMER_WIDTH)
	) i_timer (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.bus     (timer_bus),
		.match_o (timer_match)
	);

	jelly_uart_tx #(
		.BAUD_DIV (BAUD_DIV)
	) i_uart_tx (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.bus     (uart_bus),
		.tx_o    (uart_tx_o),
		.done_o  (uart_done)
	);

endmodule

`default_nettype wire

/* src/jelly_uart_tx.sv */
// --------------------------------------------------------------------
// jelly UART transmitter
// sends one 8N1 frame per accepted byte, BAUD_DIV clocks per bit
// --------------------------------------------------------------------

`default_nettype none

module jelly_uart_tx
	import jelly_peri_pkg::*;
	#(
		parameter int BAUD_DIV = 8
	)
	(
		input  wire logic clk_i,
		input  wire logic reset_i,
		jelly_wb_if.slave bus,
		output logic      tx_o,
		output logic      done_o
	);

	localparam int BAUD_WIDTH = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

	logic [BAUD_WIDTH-1:0] baud_cnt;
	logic [3:0]            bit_cnt;
	logic [9:0]            shift;
	logic                  busy;
	logic                  baud_last;
	logic                  last_bit;
	logic                  start;
	logic [1:0]            reg_sel;
	logic                  wr_en;

	assign reg_sel = bus.adr[REG_MSB:REG_LSB];
	assign wr_en   = bus.stb & bus.we & ~bus.ack;

	// bytes written while busy are dropped
	assign start = wr_en & (reg_sel == UART_REG_DATA) & bus.sel[0] & ~busy;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.stb & ~bus.ack;
	end

	// --------------------------------------------------------------------
	//  frame engine
	// --------------------------------------------------------------------

	assign baud_last = (baud_cnt == BAUD_WIDTH'(BAUD_DIV - 1));
	assign last_bit  = (bit_cnt == 4'd9);

	// shift idles at all ones so the line rests high
	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			shift    <= '1;
		end
		else if (start)
		begin
			busy     <= 1'b1;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			shift    <= {1'b1, bus.dat_w[7:0], 1'b0};
		end
		else if (busy)
		begin
			if (baud_last)
			begin
				baud_cnt <= '0;
				shift    <= {1'b1, shift[9:1]};
				if (last_bit)
					busy <= 1'b0;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
			else
			begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	assign tx_o = shift[0];

	// with the final stop bit cycle
	assign done_o = busy & baud_last & last_bit;

	always_comb
	begin
		case (reg_sel)
			UART_REG_STATUS: bus.dat_r = WB_DAT_WIDTH'(busy);
			default:         bus.dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/jelly_irc.sv */
// --------------------------------------------------------------------
// jelly interrupt controller
// pending and enable masks with a single request/acknowledge
// handshake toward the CPU, lowest factor number first
// --------------------------------------------------------------------

`default_nettype none

module jelly_irc
	import jelly_peri_pkg::*;
	(
		input  wire logic                  clk_i,
		input  wire logic                  reset_i,
		jelly_wb_if.slave                  bus,
		input  wire logic [FACTOR_NUM-1:0] factor_i,
		output logic                       irq_o,
		input  wire logic                  irq_ack_i
	);

	logic [FACTOR_NUM-1:0]      enable;
	logic [FACTOR_NUM-1:0]      pending;
	logic [FACTOR_NUM-1:0]      request;
	logic [FACTOR_NUM-1:0]      sw_clear;
	logic [FACTOR_NUM-1:0]      hw_clear;
	logic [FACTOR_ID_WIDTH-1:0] lowest_id;
	logic [FACTOR_ID_WIDTH-1:0] factor_id;
	irc_state_t                 state;
	logic [1:0]                 reg_sel;
	logic                       wr_en;

	assign reg_sel = bus.adr[REG_MSB:REG_LSB];
	assign wr_en   = bus.stb & bus.we & ~bus.ack;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.stb & ~bus.ack;
	end

	// --------------------------------------------------------------------
	//  enable and pending
	// --------------------------------------------------------------------

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			enable <= '0;
		else if (wr_en && reg_sel == IRC_REG_ENABLE)
			enable <= FACTOR_NUM'(wb_write_lanes(WB_DAT_WIDTH'(enable),
			                                     bus.dat_w, bus.sel));
	end

	// write 1 to clear
	assign sw_clear = (wr_en && reg_sel == IRC_REG_PENDING && bus.sel[0]) ?
	                  bus.dat_w[FACTOR_NUM-1:0] : '0;

	// the served factor drops in CLEAR
	assign hw_clear = (state == CLEAR) ? (FACTOR_NUM'(1) << factor_id) : '0;

	// a new event in the same cycle beats the clear
	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			pending <= '0;
		else
			pending <= (pending & ~(sw_clear | hw_clear)) | factor_i;
	end

	assign request = pending & enable;

	// lowest number wins
	always_comb
	begin
		lowest_id = '0;
		for (int i = FACTOR_NUM - 1; i >= 0; i--)
		begin
			if (request[i])
				lowest_id = FACTOR_ID_WIDTH'(i);
		end
	end

	// --------------------------------------------------------------------
	//  CPU handshake FSM
	// --------------------------------------------------------------------

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state     <= IDLE;
			factor_id <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (|request)
					begin
						factor_id <= lowest_id;
						state     <= REQUEST;
					end
				end
				REQUEST:
				begin
					if (irq_ack_i)
						state <= CLEAR;
				end
				CLEAR:   state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign irq_o = (state == REQUEST);

	always_comb
	begin
		case (reg_sel)
			IRC_REG_ENABLE:  bus.dat_r = WB_DAT_WIDTH'(enable);
			IRC_REG_PENDING: bus.dat_r = WB_DAT_WIDTH'(pending);
			IRC_REG_FACTOR:  bus.dat_r = WB_DAT_WIDTH'(factor_id);
			default:         bus.dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/jelly_timer.sv */
// --------------------------------------------------------------------
// jelly compare-match timer
// free running counter that wraps on compare and pulses match
// --------------------------------------------------------------------

`default_nettype none

module jelly_timer
	import jelly_peri_pkg::*;
	#(
		parameter int TIMER_WIDTH = 32
	)
	(
		input  wire logic clk_i,
		input  wire logic reset_i,
		jelly_wb_if.slave bus,
		output logic      match_o
	);

	logic                   enable;
	logic [TIMER_WIDTH-1:0] compare;
	logic [TIMER_WIDTH-1:0] counter;
	logic [1:0]             reg_sel;
	logic                   wr_en;
	logic                   wr_ctrl;
	logic                   clear;

	assign reg_sel = bus.adr[REG_MSB:REG_LSB];

	// write lands on the edge that raises ack
	assign wr_en   = bus.stb & bus.we & ~bus.ack;
	assign wr_ctrl = wr_en & (reg_sel == TIMER_REG_CONTROL) & bus.sel[0];
	assign clear   = wr_ctrl & bus.dat_w[1];

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.stb & ~bus.ack;
	end

	// --------------------------------------------------------------------
	//  control and compare registers
	// --------------------------------------------------------------------

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			enable  <= 1'b0;
			compare <= '0;
		end
		else
		begin
			if (wr_ctrl)
				enable <= bus.dat_w[0];
			if (wr_en && reg_sel == TIMER_REG_COMPARE)
				compare <= TIMER_WIDTH'(wb_write_lanes(WB_DAT_WIDTH'(compare),
				                                       bus.dat_w, bus.sel));
		end
	end

	// counter wraps to zero in the cycle it equals compare
	assign match_o = enable & (counter == compare);

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			counter <= '0;
		else if (clear)
			counter <= '0;
		else if (match_o)
			counter <= '0;
		else if (enable)
			counter <= counter + 1'b1;
	end

	// read back, clear bit always reads zero
	always_comb
	begin
		case (reg_sel)
			TIMER_REG_CONTROL: bus.dat_r = WB_DAT_WIDTH'(enable);
			TIMER_REG_COMPARE: bus.dat_r = WB_DAT_WIDTH'(compare);
			TIMER_REG_COUNTER: bus.dat_r = WB_DAT_WIDTH'(counter);
			default:           bus.dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/jelly_peri_decoder.sv */
// --------------------------------------------------------------------
// jelly peripheral address decoder
// routes strobe by region and returns the selected slave's response,
// unmapped regions get a local ack with zero data
// --------------------------------------------------------------------

`default_nettype none

module jelly_peri_decoder
	import jelly_peri_pkg::*;
	(
		input  wire logic                    clk_i,
		input  wire logic                    reset_i,

		input  wire logic [WB_ADR_WIDTH-1:0] wb_adr_i,
		input  wire logic [WB_DAT_WIDTH-1:0] wb_dat_i,
		output logic      [WB_DAT_WIDTH-1:0] wb_dat_o,
		input  wire logic                    wb_we_i,
		input  wire logic [WB_SEL_WIDTH-1:0] wb_sel_i,
		input  wire logic                    wb_stb_i,
		output logic                         wb_ack_o,

		jelly_wb_if.master                   irc_bus,
		jelly_wb_if.master                   timer_bus,
		jelly_wb_if.master                   uart_bus
	);

	logic [REGION_WIDTH-1:0] region;
	logic                    hit_irc;
	logic                    hit_timer;
	logic                    hit_uart;
	logic                    unmapped;
	logic                    none_ack;

	assign region    = wb_adr_i[REGION_MSB:REGION_LSB];
	assign hit_irc   = (region == REGION_IRC);
	assign hit_timer = (region == REGION_TIMER);
	assign hit_uart  = (region == REGION_UART);
	assign unmapped  = ~(hit_irc | hit_timer | hit_uart);

	// --------------------------------------------------------------------
	//  request side, broadcast everything but the strobe
	// --------------------------------------------------------------------

	assign irc_bus.adr   = wb_adr_i;
	assign irc_bus.dat_w = wb_dat_i;
	assign irc_bus.we    = wb_we_i;
	assign irc_bus.sel   = wb_sel_i;
	assign irc_bus.stb   = wb_stb_i & hit_irc;

	assign timer_bus.adr   = wb_adr_i;
	assign timer_bus.dat_w = wb_dat_i;
	assign timer_bus.we    = wb_we_i;
	assign timer_bus.sel   = wb_sel_i;
	assign timer_bus.stb   = wb_stb_i & hit_timer;

	assign uart_bus.adr   = wb_adr_i;
	assign uart_bus.dat_w = wb_dat_i;
	assign uart_bus.we    = wb_we_i;
	assign uart_bus.sel   = wb_sel_i;
	assign uart_bus.stb   = wb_stb_i & hit_uart;

	// local ack for holes in the map, same one cycle latency as a slave
	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			none_ack <= 1'b0;
		else
			none_ack <= wb_stb_i & unmapped & ~none_ack;
	end

	// --------------------------------------------------------------------
	//  response side
	// --------------------------------------------------------------------

	always_comb
	begin
		case (region)
			REGION_IRC:
			begin
				wb_dat_o = irc_bus.dat_r;
				wb_ack_o = irc_bus.ack;
			end
			REGION_TIMER:
			begin
				wb_dat_o = timer_bus.dat_r;
				wb_ack_o = timer_bus.ack;
			end
			REGION_UART:
			begin
				wb_dat_o = uart_bus.dat_r;
				wb_ack_o = uart_bus.ack;
			end
			default:
			begin
				wb_dat_o = '0;
				wb_ack_o = none_ack;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/jelly_wb_if.sv */
// --------------------------------------------------------------------
// jelly peripheral bus interface
// strobe/acknowledge bus between the decoder and one slave
// --------------------------------------------------------------------

`default_nettype none

interface jelly_wb_if
	import jelly_peri_pkg::*;
	();

	logic [WB_ADR_WIDTH-1:0] adr;
	logic [WB_DAT_WIDTH-1:0] dat_w;
	logic [WB_DAT_WIDTH-1:0] dat_r;
	logic                    we;
	logic [WB_SEL_WIDTH-1:0] sel;
	logic                    stb;
	logic                    ack;

	// decoder side
	modport master
	(
		output adr,
		output dat_w,
		output we,
		output sel,
		output stb,
		input  dat_r,
		input  ack
	);

	// register block side
	modport slave
	(
		input  adr,
		input  dat_w,
		input  we,
		input  sel,
		input  stb,
		output dat_r,
		output ack
	);

endinterface

`default_nettype wire

/* src/jelly_peri_pkg.sv */
// --------------------------------------------------------------------
// jelly peripheral package
// bus widths, address map, register offsets and interrupt factors
// --------------------------------------------------------------------

`default_nettype none

package jelly_peri_pkg;

	// bus geometry
	localparam int WB_DAT_WIDTH = 32;
	localparam int WB_SEL_WIDTH = WB_DAT_WIDTH / 8;
	localparam int WB_ADR_WIDTH = 12;

	// address fields
	localparam int REGION_MSB   = 11;
	localparam int REGION_LSB   = 8;
	localparam int REGION_WIDTH = REGION_MSB - REGION_LSB + 1;
	localparam int REG_MSB      = 3;
	localparam int REG_LSB      = 2;

	localparam logic [REGION_WIDTH-1:0] REGION_IRC   = 4'd0;
	localparam logic [REGION_WIDTH-1:0] REGION_TIMER = 4'd1;
	localparam logic [REGION_WIDTH-1:0] REGION_UART  = 4'd2;

	localparam logic [1:0] IRC_REG_ENABLE    = 2'd0;
	localparam logic [1:0] IRC_REG_PENDING   = 2'd1;
	localparam logic [1:0] IRC_REG_FACTOR    = 2'd2;
	localparam logic [1:0] TIMER_REG_CONTROL = 2'd0;
	localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;
	localparam logic [1:0] TIMER_REG_COUNTER = 2'd2;
	localparam logic [1:0] UART_REG_DATA     = 2'd0;
	localparam logic [1:0] UART_REG_STATUS   = 2'd1;

	// interrupt factors, lowest number wins
	localparam int FACTOR_NUM      = 3;
	localparam int FACTOR_ID_WIDTH = 2;
	localparam int FACTOR_TIMER    = 0;
	localparam int FACTOR_UART_TX  = 1;
	localparam int FACTOR_EXT      = 2;

	typedef enum logic [1:0] {IDLE, REQUEST, CLEAR} irc_state_t;

	// merge write data into a register, byte lane by byte lane
	function automatic logic [WB_DAT_WIDTH-1:0] wb_write_lanes(
		input logic [WB_DAT_WIDTH-1:0] cur,
		input logic [WB_DAT_WIDTH-1:0] wdat,
		input logic [WB_SEL_WIDTH-1:0] sel
	);
		logic [WB_DAT_WIDTH-1:0] res;
		res = cur;
		for (int i = 0; i < WB_SEL_WIDTH; i++)
		begin
			if (sel[i])
				res[i*8 +: 8] = wdat[i*8 +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire
